// ==== filelist.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/ucode_pkg.sv
verilog/instruction_decoder.sv
verilog/fetch_execute_sequencer.sv
verilog/control_word_former.sv
verilog/control_unit.sv
tests/tb_control_unit.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_control_unit
FILELIST  := filelist.f
BUILD_DIR := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only if the pass message shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module tb_control_unit;

    import isa_pkg::*;
    import ucode_pkg::*;

    localparam int max_cycles = 3000;    // Two runs take about 1400

    typedef enum {WAIT_ORIGIN, FETCH, EXECUTE, HALTED} tb_phase_t;

    logic                       clk;
    logic                       reset;
    opcode_t                    opcode;
    logic [`CPU_FLAG_WIDTH-1:0] flags;
    control_word_t              control_word;
    logic                       last_microstep;

    // Program memory and datapath model
    logic [7:0]                 prog [256];
    int                         prog_len;
    logic [15:0]                pc;
    logic [7:0]                 temp_1;
    logic [7:0]                 temp_2;
    opcode_t                    opcode_next;
    logic [`CPU_FLAG_WIDTH-1:0] flags_next;

    // Per instruction tracking
    tb_phase_t                  phase;
    logic [7:0]                 cur_op;
    logic [`CPU_FLAG_WIDTH-1:0] cur_flags;
    logic                       exp_taken;
    logic                       pc_low_seen;
    logic                       pc_high_seen;
    int                         step;
    int                         pulses;
    int                         bytes_due;
    int                         pulse_due;
    int                         fetch_start;
    int                         last_pulse;
    int                         halted_cycles;

    int                         seed;
    int                         flag_rnd;
    int                         cycle;
    int                         value_errors;
    int                         sequence_errors;

    control_unit dut0 (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .flags          (flags),
        .control_word   (control_word),
        .last_microstep (last_microstep)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // Expected behavior per opcode
    // ======================================================================
    function automatic int operand_bytes(input logic [7:0] op);
        case (op)
            LDI_A, ANI: return 1;
            JMP, JZ, JNZ, JC, JNC, JN, JNN, LDA, STA: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic logic jump_taken(input logic [7:0] op, input logic [2:0] f);
        case (op)
            JMP: return 1'b1;
            JZ:  return f[flag_zero];
            JNZ: return !f[flag_zero];
            JC:  return f[flag_carry];
            JNC: return !f[flag_carry];
            JN:  return f[flag_negative];
            JNN: return !f[flag_negative];
            default: return 1'b0;
        endcase
    endfunction

    function automatic int exec_steps(input logic [7:0] op, input logic taken);
        case (op)
            JMP, JZ, JNZ, JC, JNC, JN, JNN: return taken ? 2 : 1;
            ADD_B, SUB_B, ANA_B, ANI, CMP_B: return 2;
            LDA, STA: return 6;
            default: return 1;    // Single step or halt
        endcase
    endfunction

    function automatic alu_op_t expected_alu(input logic [7:0] op);
        case (op)
            ADD_B: return ALU_ADD;
            SUB_B, CMP_B: return ALU_SUB;
            ANA_B, ANI: return ALU_AND;
            default: return ALU_UNDEFINED;
        endcase
    endfunction

    function automatic logic is_halting(input logic [7:0] op);
        case (op)
            NOP, JMP, JZ, JNZ, JC, JNC, JN, JNN, ADD_B, SUB_B, ANA_B, ANI, CMP_B,
            LDI_A, MOV_AB, LDA, STA, SEC, CLC: return 1'b0;
            default: return 1'b1;    // HLT and unknown opcodes
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        value_errors++;
        $display("FAIL %s: got %h, expected %h at cycle %0d", name, got, exp, cycle);
    endtask

    task automatic report_problem(input string what);
        sequence_errors++;
        $display("Cycle %0d: %s", cycle, what);
    endtask

    // Both outputs quiet
    task automatic check_idle_outputs();
        assert (control_word == '0)
            else report_mismatch("control_word", control_word, 0);
        assert (!last_microstep)
            else report_mismatch("last_microstep", last_microstep, 0);
    endtask

    // ======================================================================
    // Program builder
    // ======================================================================
    task automatic append_byte(input logic [7:0] b);
        prog[prog_len] = b;
        prog_len++;
    endtask

    task automatic append_operand();
        int rnd;
        rnd = $random(seed);
        append_byte(rnd[7:0]);
    endtask

    task automatic append_jump(input logic [7:0] op);
        append_byte(op);
        append_byte(8'(prog_len + 3));    // Target skips the NOP below
        append_byte(8'h00);
        append_byte(NOP);
    endtask

    task automatic load_program(input logic [7:0] last_op);
        for (int i = 0; i < 256; i++) begin
            prog[i] = 8'(i) ^ 8'hc3;
        end
        prog_len = 0;
        for (int r = 0; r < 3; r++) begin
            append_byte(NOP);
            append_jump(JMP);
            append_jump(JZ);
            append_jump(JNZ);
            append_jump(JC);
            append_jump(JNC);
            append_jump(JN);
            append_jump(JNN);
            append_byte(ADD_B);
            append_byte(SUB_B);
            append_byte(ANA_B);
            append_byte(CMP_B);
            append_byte(ANI);
            append_operand();
            append_byte(LDI_A);
            append_operand();
            append_byte(MOV_AB);
            append_byte(LDA);
            append_operand();
            append_operand();
            append_byte(STA);
            append_operand();
            append_operand();
            append_byte(SEC);
            append_byte(CLC);
        end
        append_byte(last_op);
    endtask

    task automatic start_fetch(input int first_cycle);
        phase       = FETCH;
        fetch_start = first_cycle;
        pulse_due   = first_cycle + 2;    // Opcode latched in the third cycle
        pulses      = 0;
        bytes_due   = 1;
    endtask

    task automatic run_program();
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (!(phase == HALTED && halted_cycles >= 20)) begin
            @(posedge clk);
        end
    endtask

    // Inputs change only on the rising edge
    always @(posedge clk) begin
        cycle++;
        opcode <= opcode_next;
        flags  <= flags_next;
        if (cycle >= max_cycles) begin
            $display("Timeout: CPU did not reach halt within %0d cycles", max_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // ======================================================================
    // Monitor, samples outputs mid cycle
    // ======================================================================
    always @(negedge clk) begin
        if (reset) begin
            check_idle_outputs();
            phase         = WAIT_ORIGIN;
            pc            = '0;
            opcode_next   = NOP;
            halted_cycles = 0;
        end else begin
            case (phase)
                WAIT_ORIGIN: begin
                    if (control_word.load_origin) begin
                        start_fetch(cycle + 1);
                    end else begin
                        check_idle_outputs();
                    end
                end
                FETCH: begin
                    assert (!last_microstep) else report_problem("last_microstep during fetch");
                    if (cycle == fetch_start) begin
                        assert (control_word.load_mar_pc)
                            else report_problem("no MAR load from PC at start of fetch");
                    end
                    if (control_word.pc_enable) begin
                        assert (cycle == pulse_due) else report_problem("pc_enable out of step");
                        assert (pulses < bytes_due)
                            else report_problem("more bytes fetched than the opcode has");
                        assert (control_word.load_ir == (pulses == 0))
                            else report_mismatch("load_ir", control_word.load_ir, pulses == 0);
                        assert (control_word.load_temp_1 == (pulses == 1))
                            else report_mismatch("load_temp_1", control_word.load_temp_1,
                                                 pulses == 1);
                        assert (control_word.load_temp_2 == (pulses == 2))
                            else report_mismatch("load_temp_2", control_word.load_temp_2,
                                                 pulses == 2);
                        if (pulses == 0) begin
                            cur_op      = prog[pc[7:0]];
                            opcode_next = opcode_t'(cur_op);
                            flag_rnd    = $random(seed);
                            flags_next  = flag_rnd[`CPU_FLAG_WIDTH-1:0];
                            cur_flags   = flags_next;
                            bytes_due   = 1 + operand_bytes(cur_op);
                        end else if (pulses == 1) begin
                            temp_1 = prog[pc[7:0]];
                        end else begin
                            temp_2 = prog[pc[7:0]];
                        end
                        pulses++;
                        pc++;
                        last_pulse = cycle;
                        pulse_due  = cycle + 4;
                    end else if (pulses < bytes_due) begin
                        assert (cycle != pulse_due) else report_problem("pc_enable missing");
                    end else if (cycle == last_pulse + 1) begin
                        phase        = EXECUTE;    // Execute follows the check cycle
                        step         = 0;
                        pc_low_seen  = 1'b0;
                        pc_high_seen = 1'b0;
                        exp_taken    = jump_taken(cur_op, cur_flags);
                    end
                end
                EXECUTE: begin
                    assert (!(control_word.load_mar_pc || control_word.pc_enable ||
                              control_word.load_ir))
                        else report_problem("fetch strobe during execute");
                    assert (control_word.alu_op == expected_alu(cur_op))
                        else report_mismatch("alu_op", control_word.alu_op,
                                             expected_alu(cur_op));
                    if (control_word.load_pc_low_byte) begin
                        assert (exp_taken && step == 0)
                            else report_problem("PC low byte loaded on a jump not taken");
                        pc_low_seen = 1'b1;
                    end
                    if (control_word.load_pc_high_byte) begin
                        assert (exp_taken && step == 1)
                            else report_problem("PC high byte loaded on a jump not taken");
                        pc_high_seen = 1'b1;
                        if (pc_low_seen) begin
                            pc = {temp_2, temp_1};
                        end
                    end
                    if (last_microstep) begin
                        assert (step + 1 == exec_steps(cur_op, exp_taken))
                            else report_mismatch("step count", step + 1,
                                                 exec_steps(cur_op, exp_taken));
                        assert (pc_low_seen == exp_taken && pc_high_seen == exp_taken)
                            else report_problem("PC load strobes do not follow the jump");
                        assert (control_word.halt == is_halting(cur_op))
                            else report_mismatch("halt", control_word.halt, is_halting(cur_op));
                        if (is_halting(cur_op)) begin
                            phase = HALTED;
                        end else begin
                            start_fetch(cycle + 1);
                        end
                    end else begin
                        step++;
                        assert (step < exec_steps(cur_op, exp_taken))
                            else report_problem("last_microstep missing at end of instruction");
                    end
                end
                HALTED: begin
                    check_idle_outputs();
                    halted_cycles++;
                end
                default: ;
            endcase
        end
    end

    initial begin
        reset           = 1'b1;
        opcode          = NOP;
        flags           = '0;
        opcode_next     = NOP;
        flags_next      = '0;
        seed            = 82835;
        cycle           = 0;
        value_errors    = 0;
        sequence_errors = 0;
        phase           = WAIT_ORIGIN;
        pc              = '0;
        temp_1          = '0;
        temp_2          = '0;
        halted_cycles   = 0;

        load_program(HLT);
        run_program();
        load_program(8'hff);    // Unknown opcode must halt too
        run_program();

        $display("Error counts: %0d value, %0d sequence", value_errors, sequence_errors);
        if (value_errors == 0 && sequence_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module control_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  isa_pkg::opcode_t               opcode,       // From the IR
    input  logic [`CPU_FLAG_WIDTH-1:0]     flags,
    output ucode_pkg::control_word_t       control_word,
    output logic                           last_microstep
);

    import isa_pkg::*;
    import ucode_pkg::*;

    operand_count_t operand_count;
    control_word_t  rom_word;
    seq_state_t     state;
    logic [1:0]     byte_count;
    microstep_t     microstep;
    logic           step_end;
    logic           halt_step;

    // ======================================================================
    // Decode, sequence, form
    // ======================================================================
    instruction_decoder decoder0 (
        .opcode        (opcode),
        .microstep     (microstep),
        .operand_count (operand_count),
        .rom_word      (rom_word)
    );

    fetch_execute_sequencer sequencer0 (
        .clk           (clk),
        .reset         (reset),
        .operand_count (operand_count),
        .step_end      (step_end),
        .halt_step     (halt_step),
        .state         (state),
        .byte_count    (byte_count),
        .microstep     (microstep)
    );

    control_word_former former0 (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .byte_count     (byte_count),
        .microstep      (microstep),
        .rom_word       (rom_word),
        .flags          (flags),
        .control_word   (control_word),
        .last_microstep (last_microstep),
        .step_end       (step_end),
        .halt_step      (halt_step)
    );

endmodule

`default_nettype wire

// ==== verilog/control_word_former.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module control_word_former (
    input  logic                           clk,
    input  logic                           reset,
    input  ucode_pkg::seq_state_t          state,
    input  logic [1:0]                     byte_count,
    input  ucode_pkg::microstep_t          microstep,
    input  ucode_pkg::control_word_t       rom_word,
    input  logic [`CPU_FLAG_WIDTH-1:0]     flags,
    output ucode_pkg::control_word_t       control_word,
    output logic                           last_microstep,
    output logic                           step_end,
    output logic                           halt_step
);

    import ucode_pkg::*;

    alu_op_t alu_op_q;       // ALU op held across the instruction
    logic    branch_check;
    logic    branch_taken;

    // ALU op comes from microstep 0 only
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op_q <= ALU_UNDEFINED;
        end else if (state == S_EXECUTE && microstep == '0) begin
            alu_op_q <= rom_word.alu_op;
        end
    end

    // ======================================================================
    // Branch resolution
    // ======================================================================
    assign branch_check = rom_word.check_zero  | rom_word.check_not_zero  |
                          rom_word.check_carry | rom_word.check_not_carry |
                          rom_word.check_negative | rom_word.check_not_negative;

    assign branch_taken =
        (rom_word.check_zero         &  flags[isa_pkg::flag_zero])     |
        (rom_word.check_not_zero     & ~flags[isa_pkg::flag_zero])     |
        (rom_word.check_carry        &  flags[isa_pkg::flag_carry])    |
        (rom_word.check_not_carry    & ~flags[isa_pkg::flag_carry])    |
        (rom_word.check_negative     &  flags[isa_pkg::flag_negative]) |
        (rom_word.check_not_negative & ~flags[isa_pkg::flag_negative]);

    // ======================================================================
    // Output word per phase
    // ======================================================================
    always_comb begin
        control_word = '0;    // S_RESET and S_HALT stay all zero
        step_end     = 1'b0;
        halt_step    = 1'b0;
        case (state)
            S_INIT:       control_word.load_origin = 1'b1;
            S_LATCH_ADDR: control_word.load_mar_pc = 1'b1;
            S_READ_BYTE:  control_word.oe_ram = 1'b1;
            S_LATCH_BYTE: begin
                control_word.oe_ram      = 1'b1;
                control_word.pc_enable   = 1'b1;
                control_word.load_ir     = (byte_count == 2'd0);
                control_word.load_temp_1 = (byte_count == 2'd1);
                control_word.load_temp_2 = (byte_count == 2'd2);
            end
            S_EXECUTE: begin
                control_word = rom_word;
                if (microstep != '0) begin
                    control_word.alu_op = alu_op_q;
                end
                if (branch_check && !branch_taken) begin
                    // Condition failed so PC keeps pointing past the operands
                    control_word.load_pc_low_byte  = 1'b0;
                    control_word.load_pc_high_byte = 1'b0;
                end
                halt_step = rom_word.halt;
                step_end  = rom_word.last_step | (branch_check & ~branch_taken);
            end
            default: ;
        endcase
    end

    assign last_microstep = step_end | halt_step;

endmodule

`default_nettype wire

// ==== verilog/fetch_execute_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_execute_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  isa_pkg::operand_count_t  operand_count,
    input  logic                     step_end,
    input  logic                     halt_step,
    output ucode_pkg::seq_state_t    state,
    output logic [1:0]               byte_count,
    output ucode_pkg::microstep_t    microstep
);

    import ucode_pkg::*;

    // ======================================================================
    // Phase FSM with byte and microstep counters
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            byte_count <= 2'd0;
            microstep  <= '0;
        end else begin
            case (state)
                S_RESET: begin
                    state <= S_INIT;
                end

                S_INIT: begin
                    state <= S_LATCH_ADDR;      // Datapath loads the origin here
                end

                // Four cycles per fetched byte
                S_LATCH_ADDR: begin
                    state <= S_READ_BYTE;
                end

                S_READ_BYTE: begin
                    state <= S_LATCH_BYTE;
                end

                S_LATCH_BYTE: begin
                    state      <= S_CHK_MORE_BYTES;
                    byte_count <= byte_count + 2'd1;
                end

                S_CHK_MORE_BYTES: begin
                    // Opcode is in the IR by now so operand_count is valid
                    if (byte_count > operand_count) begin
                        state      <= S_EXECUTE;
                        byte_count <= 2'd0;
                    end else begin
                        state <= S_LATCH_ADDR;
                    end
                end

                S_EXECUTE: begin
                    if (halt_step) begin
                        state     <= S_HALT;
                        microstep <= '0;
                    end else if (step_end) begin
                        state     <= S_LATCH_ADDR;   // Next instruction
                        microstep <= '0;
                    end else begin
                        microstep <= microstep + 1'b1;
                    end
                end

                S_HALT: begin
                    state <= S_HALT;    // Only reset leaves
                end

                default: begin
                    state <= S_HALT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instruction_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module instruction_decoder (
    input  isa_pkg::opcode_t          opcode,
    input  ucode_pkg::microstep_t     microstep,
    output isa_pkg::operand_count_t   operand_count,
    output ucode_pkg::control_word_t  rom_word
);

    import isa_pkg::*;
    import ucode_pkg::*;

    // ======================================================================
    // Operand byte count
    // ======================================================================
    always_comb begin
        case (opcode)
            LDI_A, ANI: begin
                operand_count = 2'd1;
            end
            JMP, JZ, JNZ, JC, JNC, JN, JNN, LDA, STA: begin
                operand_count = 2'd2;    // Address low then high
            end
            default: begin
                operand_count = 2'd0;    // Also unknown opcodes
            end
        endcase
    end

    // ======================================================================
    // Microcode ROM
    // ======================================================================
    control_word_t rom [`CPU_ROM_DEPTH][`CPU_MAX_MICROSTEPS];

    assign rom_word = rom[opcode][microstep];

    initial begin
        // Every row starts as a halt so unknown opcodes stop the CPU
        for (int i = 0; i < `CPU_ROM_DEPTH; i++) begin
            for (int s = 0; s < `CPU_MAX_MICROSTEPS; s++) begin
                rom[i][s] = '0;
            end
            rom[i][0] = '{default: 0, alu_op: ALU_UNDEFINED, halt: 1};
        end

        rom[NOP][0] = '{default: 0, alu_op: ALU_UNDEFINED, last_step: 1};
        rom[HLT][0] = '{default: 0, alu_op: ALU_UNDEFINED, halt: 1};

        // Branches load PC low at step 0, the check may cancel it
        rom[JMP][0] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1};
        rom[JZ][0]  = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1,
                        check_zero: 1};
        rom[JNZ][0] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1,
                        check_not_zero: 1};
        rom[JC][0]  = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1,
                        check_carry: 1};
        rom[JNC][0] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1,
                        check_not_carry: 1};
        rom[JN][0]  = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1,
                        check_negative: 1};
        rom[JNN][0] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_pc_low_byte: 1,
                        check_not_negative: 1};
        // High byte step is the same for every jump
        rom[JMP][1] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_2: 1, load_pc_high_byte: 1,
                        last_step: 1};
        rom[JZ][1]  = rom[JMP][1];
        rom[JNZ][1] = rom[JMP][1];
        rom[JC][1]  = rom[JMP][1];
        rom[JNC][1] = rom[JMP][1];
        rom[JN][1]  = rom[JMP][1];
        rom[JNN][1] = rom[JMP][1];

        // ALU ops select at step 0, write back at step 1
        rom[ADD_B][0] = '{default: 0, alu_op: ALU_ADD};
        rom[SUB_B][0] = '{default: 0, alu_op: ALU_SUB};
        rom[ANA_B][0] = '{default: 0, alu_op: ALU_AND};
        rom[ANI][0]   = '{default: 0, alu_op: ALU_AND, oe_temp_1: 1, alu_src2_temp1: 1};
        rom[ADD_B][1] = '{default: 0, alu_op: ALU_UNDEFINED, oe_alu: 1, load_a: 1,
                          load_status: 1, last_step: 1};
        rom[SUB_B][1] = rom[ADD_B][1];
        rom[ANA_B][1] = rom[ADD_B][1];
        rom[ANI][1]   = rom[ADD_B][1];
        rom[CMP_B][0] = '{default: 0, alu_op: ALU_SUB};
        rom[CMP_B][1] = '{default: 0, alu_op: ALU_UNDEFINED, load_status: 1, last_step: 1};

        rom[LDI_A][0]  = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_a: 1,
                           load_status: 1, load_sets_zn: 1, last_step: 1};
        rom[MOV_AB][0] = '{default: 0, alu_op: ALU_UNDEFINED, oe_a: 1, load_b: 1, last_step: 1};

        // Memory access through MAR, address from temp_1/temp_2
        rom[LDA][0] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1};
        rom[LDA][1] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_1: 1, load_mar_addr_low: 1};
        rom[LDA][2] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_2: 1};
        rom[LDA][3] = '{default: 0, alu_op: ALU_UNDEFINED, oe_temp_2: 1, load_mar_addr_high: 1};
        rom[LDA][4] = '{default: 0, alu_op: ALU_UNDEFINED, oe_ram: 1};
        rom[LDA][5] = '{default: 0, alu_op: ALU_UNDEFINED, oe_ram: 1, load_a: 1,
                        load_status: 1, load_sets_zn: 1, last_step: 1};
        for (int s = 0; s < 4; s++) begin
            rom[STA][s] = rom[LDA][s];    // Same address phase
        end
        rom[STA][4] = '{default: 0, alu_op: ALU_UNDEFINED, oe_a: 1};
        rom[STA][5] = '{default: 0, alu_op: ALU_UNDEFINED, oe_a: 1, load_ram: 1, last_step: 1};

        rom[SEC][0] = '{default: 0, alu_op: ALU_UNDEFINED, set_carry_flag: 1, load_status: 1,
                        last_step: 1};
        rom[CLC][0] = '{default: 0, alu_op: ALU_UNDEFINED, clear_carry_flag: 1, load_status: 1,
                        last_step: 1};
    end

endmodule

`default_nettype wire

// ==== verilog/ucode_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package ucode_pkg;

    typedef enum logic [`CPU_ALU_OP_WIDTH-1:0] {
        ALU_UNDEFINED = 4'h0,
        ALU_ADD       = 4'h1,
        ALU_SUB       = 4'h2,
        ALU_AND       = 4'h3,
        ALU_OR        = 4'h4
    } alu_op_t;

    typedef logic [`CPU_MICROSTEP_WIDTH-1:0] microstep_t;

    // Fetch/execute phases
    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } seq_state_t;

    // ======================================================================
    // Control word to the datapath, one per clock
    // ======================================================================
    typedef struct packed {
        // Origin, PC and MAR
        logic    load_origin;
        logic    load_mar_pc;
        logic    pc_enable;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        // Instruction and operand latches
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        // Bus drivers
        logic    oe_ram;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_alu;
        logic    oe_a;
        // Register and memory loads
        logic    load_ram;
        logic    load_a;
        logic    load_b;
        logic    load_status;
        logic    load_sets_zn;     // Status takes Z/N from the bus value
        logic    set_carry_flag;
        logic    clear_carry_flag;
        // Branch qualifiers
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_not_carry;
        logic    check_negative;
        logic    check_not_negative;
        alu_op_t alu_op;
        logic    alu_src2_temp1;   // Second ALU operand from temp_1 not B
        logic    halt;
        logic    last_step;
    } control_word_t;

endpackage

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package isa_pkg;

    // ======================================================================
    // Opcode map
    // ======================================================================
    typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        // Absolute jumps, two address bytes
        JMP    = 8'h10,
        JZ     = 8'h11,
        JNZ    = 8'h12,
        JC     = 8'h13,
        JNC    = 8'h14,
        JN     = 8'h15,
        JNN    = 8'h16,
        // ALU group, result in A
        ADD_B  = 8'h20,
        SUB_B  = 8'h21,
        ANA_B  = 8'h22,
        ANI    = 8'h23,   // Immediate operand
        CMP_B  = 8'h24,   // Flags only
        // Loads, stores and moves
        LDI_A  = 8'h30,
        MOV_AB = 8'h31,
        LDA    = 8'h40,
        STA    = 8'h41,
        // Carry flag control
        SEC    = 8'h50,
        CLC    = 8'h51
    } opcode_t;

    // Operand bytes following the opcode
    typedef logic [1:0] operand_count_t;

    // Bit positions in the status flags from the datapath
    localparam int flag_zero     = 0;
    localparam int flag_carry    = 1;
    localparam int flag_negative = 2;

endpackage

`default_nettype wire

// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ======================================================================
// Datapath widths
// ======================================================================
`define CPU_OPCODE_WIDTH    8
`define CPU_FLAG_WIDTH      3   // Zero, carry, negative
`define CPU_ALU_OP_WIDTH    4

// ======================================================================
// Microcode ROM geometry
// ======================================================================
`define CPU_MAX_MICROSTEPS  8   // Steps per opcode
`define CPU_MICROSTEP_WIDTH 3

// One ROM row per possible opcode value
`define CPU_ROM_DEPTH       (1 << `CPU_OPCODE_WIDTH)

`endif
